// ==== source/soc_defines.svh ====
/*
 * Address map, scratch RAM depth and serial bit timing
 */

`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Serial bit time in clocks
`define SOC_CLKS_PER_BIT 104

// Scratch RAM
`define SOC_RAM_WORDS 256
`define SOC_RAM_LIMIT 32'h0000_0400 // First byte above the RAM

// Peripheral registers
`define SOC_LED_ADDR  32'h0200_0000
`define SOC_UART_ADDR 32'h0200_0004

`endif

// ==== source/soc_pkg.sv ====
/*
 * Shared vector types and FSM state encodings
 */

package soc_pkg;

	typedef logic [31:0] addr_t; // Byte address
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [7:0]  byte_t; // Serial character
	typedef logic [4:0]  led_t;

	typedef enum logic [1:0] {DEC_IDLE, DEC_WAIT, DEC_ACK} dec_state_e;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage

// ==== source/mem_if.sv ====
/*
 * Request path from the bus decoder to the serial port
 */

`timescale 1ns/1ps

interface mem_if;

	logic          wvalid; // Level requests, held until done
	logic          rvalid;
	soc_pkg::word_t wdata;
	soc_pkg::word_t rdata;
	logic          done;   // Single cycle

	modport master (
		output wvalid,
		output rvalid,
		output wdata,
		input  rdata,
		input  done
	);

	modport slave (
		input  wvalid,
		input  rvalid,
		input  wdata,
		output rdata,
		output done
	);

endinterface

// ==== source/uart_rx.sv ====
/*
 * Serial receiver, 8N1, mid-bit sampling
 */

`timescale 1ns/1ps
`include "soc_defines.svh"

module uart_rx (
	input  logic           clk,
	input  logic           resetn,
	input  logic           rx,
	output soc_pkg::byte_t data,
	output logic           valid
);

	localparam int CW = $clog2(`SOC_CLKS_PER_BIT);
	localparam logic [CW-1:0] BIT_LAST = CW'(`SOC_CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF_LAST = CW'(`SOC_CLKS_PER_BIT / 2 - 1);

	soc_pkg::rx_state_e state;
	logic rx_meta, rx_sync, rx_last;
	logic [CW-1:0] cnt;
	logic [2:0] bitn;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
			state <= soc_pkg::RX_IDLE;
			cnt <= '0;
			bitn <= '0;
			valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
			valid <= 1'b0;
			if (cnt != '0)
				cnt <= cnt - 1'b1;

			case (state)
				soc_pkg::RX_IDLE: begin
					if (rx_last && !rx_sync) begin
						cnt <= HALF_LAST; // Wait for mid start bit
						state <= soc_pkg::RX_START;
					end
				end
				soc_pkg::RX_START: begin
					if (cnt == '0) begin
						cnt <= BIT_LAST;
						bitn <= '0;
						state <= rx_sync ? soc_pkg::RX_IDLE : soc_pkg::RX_DATA; // Glitch
					end
				end
				soc_pkg::RX_DATA: begin
					if (cnt == '0) begin
						data <= {rx_sync, data[7:1]}; // LSB first
						cnt <= BIT_LAST;
						bitn <= bitn + 1'b1;
						if (bitn == 3'd7)
							state <= soc_pkg::RX_STOP;
					end
				end
				default: begin
					if (cnt == '0) begin
						valid <= rx_sync; // Drop on framing error
						state <= soc_pkg::RX_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== source/uart_tx.sv ====
/*
 * Serial transmitter, 8N1
 * A start during a frame is held until the line is idle
 */

`timescale 1ns/1ps
`include "soc_defines.svh"

module uart_tx (
	input  logic           clk,
	input  logic           resetn,
	input  logic           start,
	input  soc_pkg::byte_t data,
	output logic           tx,
	output logic           done
);

	localparam int CW = $clog2(`SOC_CLKS_PER_BIT);
	localparam logic [CW-1:0] BIT_LAST = CW'(`SOC_CLKS_PER_BIT - 1);

	soc_pkg::tx_state_e state;
	soc_pkg::byte_t hold, shreg;
	logic pend;
	logic [CW-1:0] cnt;
	logic [2:0] bitn;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= soc_pkg::TX_IDLE;
			tx <= 1'b1;
			done <= 1'b0;
			pend <= 1'b0;
			cnt <= '0;
			bitn <= '0;
		end else begin
			done <= 1'b0;
			cnt <= (cnt == BIT_LAST) ? '0 : cnt + 1'b1;

			case (state)
				soc_pkg::TX_IDLE: begin
					if (pend) begin
						shreg <= hold;
						pend <= 1'b0;
						cnt <= '0; // Bit timing restarts here
						tx <= 1'b0;
						state <= soc_pkg::TX_START;
					end
				end
				soc_pkg::TX_START: begin
					if (cnt == BIT_LAST) begin
						tx <= shreg[0];
						shreg <= shreg >> 1;
						bitn <= '0;
						state <= soc_pkg::TX_DATA;
					end
				end
				soc_pkg::TX_DATA: begin
					if (cnt == BIT_LAST) begin
						bitn <= bitn + 1'b1;
						if (bitn == 3'd7) begin
							tx <= 1'b1;
							done <= 1'b1; // Stop bit begins
							state <= soc_pkg::TX_STOP;
						end else begin
							tx <= shreg[0];
							shreg <= shreg >> 1;
						end
					end
				end
				default: begin
					if (cnt == BIT_LAST)
						state <= soc_pkg::TX_IDLE;
				end
			endcase

			if (start) begin
				hold <= data;
				pend <= 1'b1;
			end
		end
	end

endmodule

// ==== source/uart_port.sv ====
/*
 * Serial data register with 4-byte receive buffer
 */

`timescale 1ns/1ps

module uart_port (
	input  logic  clk,
	input  logic  resetn,
	input  logic  ser_rx,
	output logic  ser_tx,
	mem_if.slave  bus
);

	soc_pkg::byte_t rbuf [4];
	logic [3:0]     rbuf_valid; // Thermometer, oldest in slot 0

	soc_pkg::byte_t rx_data;
	logic rx_valid;
	logic tx_start, tx_done, tx_busy;
	logic rd_pop;

	// A received byte wins, the read waits a cycle
	assign rd_pop = bus.rvalid && !rx_valid;
	assign tx_start = bus.wvalid && !tx_busy;

	assign bus.done  = rd_pop || (bus.wvalid && tx_busy && tx_done);
	assign bus.rdata = rbuf_valid[0] ? soc_pkg::word_t'(rbuf[0]) : '1;

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			if (!rbuf_valid[0])
				rbuf[0] <= rx_data;
			else if (!rbuf_valid[1])
				rbuf[1] <= rx_data;
			else if (!rbuf_valid[2])
				rbuf[2] <= rx_data;
			else if (!rbuf_valid[3])
				rbuf[3] <= rx_data; // Lost when full
		end else if (rd_pop) begin
			for (int i = 0; i < 3; i++)
				rbuf[i] <= rbuf[i+1];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rbuf_valid <= '0;
			tx_busy <= 1'b0;
		end else begin
			if (rx_valid)
				rbuf_valid <= {rbuf_valid[2:0], 1'b1};
			else if (rd_pop)
				rbuf_valid <= rbuf_valid >> 1;

			if (tx_start)
				tx_busy <= 1'b1;
			else if (tx_done)
				tx_busy <= 1'b0;
		end
	end

	uart_rx u_rx (
		.clk    (clk),
		.resetn (resetn),
		.rx     (ser_rx),
		.data   (rx_data),
		.valid  (rx_valid)
	);

	uart_tx u_tx (
		.clk    (clk),
		.resetn (resetn),
		.start  (tx_start),
		.data   (bus.wdata[7:0]),
		.tx     (ser_tx),
		.done   (tx_done)
	);

endmodule

// ==== source/bus_decoder.sv ====
/*
 * Four-phase bus slave with address decode
 * Holds the scratch RAM, LED register and sticky bus error flag
 */

`timescale 1ns/1ps
`include "soc_defines.svh"

module bus_decoder (
	input  logic               clk,
	input  logic               resetn,
	input  logic               req,
	input  soc_pkg::addr_t     addr,
	input  soc_pkg::word_t     wdata,
	input  soc_pkg::strb_t     wstrb,
	output logic               ack,
	output soc_pkg::word_t     rdata,
	output logic               bus_error,
	output soc_pkg::led_t      leds,
	mem_if.master              uart
);

	localparam int RAM_AW = $clog2(`SOC_RAM_WORDS);
	localparam int LED_W = $bits(soc_pkg::led_t);

	soc_pkg::word_t ram [`SOC_RAM_WORDS];
	soc_pkg::dec_state_e state;

	logic sel_ram, sel_led, sel_uart;
	logic is_write;
	logic ram_we;
	logic [RAM_AW-1:0] ram_idx;

	assign sel_ram  = addr < `SOC_RAM_LIMIT;
	assign sel_led  = addr == `SOC_LED_ADDR;
	assign sel_uart = addr == `SOC_UART_ADDR;
	assign is_write = |wstrb;
	assign ram_idx  = addr[RAM_AW+1:2]; // Drop byte offset
	assign ram_we   = state == soc_pkg::DEC_IDLE && req && sel_ram && is_write;

	always_ff @(posedge clk) begin
		if (ram_we) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i])
					ram[ram_idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	// Access on the first edge, ack on the next
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= soc_pkg::DEC_IDLE;
			ack <= 1'b0;
			bus_error <= 1'b0;
			leds <= '0;
			uart.wvalid <= 1'b0;
			uart.rvalid <= 1'b0;
		end else begin
			case (state)
				soc_pkg::DEC_IDLE: begin
					if (req) begin
						state <= soc_pkg::DEC_ACK;
						rdata <= '0; // Unmapped reads return zero
						if (sel_ram) begin
							rdata <= ram[ram_idx];
						end else if (sel_led) begin
							if (wstrb[0])
								leds <= wdata[LED_W-1:0];
							rdata <= soc_pkg::word_t'(leds);
						end else if (sel_uart) begin
							uart.wvalid <= is_write;
							uart.rvalid <= !is_write;
							uart.wdata <= wdata;
							state <= soc_pkg::DEC_WAIT;
						end else begin
							bus_error <= 1'b1;
						end
					end
				end
				soc_pkg::DEC_WAIT: begin
					// Serial reads finish here in one cycle
					if (uart.done) begin
						uart.wvalid <= 1'b0;
						uart.rvalid <= 1'b0;
						rdata <= uart.rdata;
						ack <= 1'b1;
						state <= soc_pkg::DEC_ACK;
					end
				end
				default: begin
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack <= 1'b0; // Handshake complete
						state <= soc_pkg::DEC_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== source/soc_top.sv ====
/*
 * Peripheral subsystem top level
 * Four-phase bus slave with RAM, LEDs and serial port
 */

`timescale 1ns/1ps

module soc_top (
	input  logic           clk,
	input  logic           resetn,

	input  logic           req,
	input  soc_pkg::addr_t addr,
	input  soc_pkg::word_t wdata,
	input  soc_pkg::strb_t wstrb,
	output logic           ack,
	output soc_pkg::word_t rdata,
	output logic           bus_error,

	output soc_pkg::led_t  leds,

	input  logic           ser_rx,
	output logic           ser_tx
);

	mem_if uart_bus ();

	bus_decoder u_decoder (
		.clk       (clk),
		.resetn    (resetn),
		.req       (req),
		.addr      (addr),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.ack       (ack),
		.rdata     (rdata),
		.bus_error (bus_error),
		.leds      (leds),
		.uart      (uart_bus)
	);

	uart_port u_uart (
		.clk    (clk),
		.resetn (resetn),
		.ser_rx (ser_rx),
		.ser_tx (ser_tx),
		.bus    (uart_bus)
	);

endmodule

// ==== tb/tb_clock.sv ====
/*
 * Testbench clock and reset generator, 20 ns period
 */

`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held for three rising edges
	initial begin
		resetn = 1'b0;
		repeat (3) @(posedge clk);
		#2 resetn = 1'b1;
	end

endmodule

// ==== tb/soc_assert.sv ====
/*
 * Concurrent assertions on the bus handshake and the sticky error flag
 */

`timescale 1ns/1ps

module soc_assert (
	input logic clk,
	input logic resetn,
	input logic req,
	input logic ack,
	input logic bus_error
);

	int fail_count = 0; // Read by the testbench at the end

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (!resetn) $rose(ack) |-> $past(req))
		else begin
			fail_count++;
			$error("ack rose while req was low");
		end

	ack_release: assert property (@(posedge clk) disable iff (!resetn) $fell(req) |=> !ack)
		else begin
			fail_count++;
			$error("ack still high one cycle after req fell");
		end

	ack_reset: assert property (@(posedge clk) !resetn |=> !ack)
		else begin
			fail_count++;
			$error("ack high out of reset");
		end

	error_sticky: assert property (@(posedge clk) resetn |-> !$fell(bus_error))
		else begin
			fail_count++;
			$error("bus_error cleared while out of reset");
		end

endmodule

// ==== tb/soc_tb.sv ====
/*
 * Testbench top for the peripheral subsystem
 * Bus master tasks, serial driver and monitor, stimulus table and watchdog
 */

`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_tb;

	localparam int BIT_NS = `SOC_CLKS_PER_BIT * 20;
	localparam int ACK_CYCLES = 2; // Edges from raising req to seeing ack
	localparam int ACK_LIMIT = 12 * `SOC_CLKS_PER_BIT;
	localparam int RAM_CASES = 8;
	localparam int SEED = 66310;

	typedef enum {OP_WRITE, OP_READ, OP_SEND, OP_RECV, OP_LEDS, OP_BERR} op_e;

	typedef struct {
		op_e            op;
		soc_pkg::addr_t addr;
		soc_pkg::word_t wdata;
		soc_pkg::strb_t strb;
		soc_pkg::word_t exp_val;
	} step_t;

	logic clk, resetn, req, ack, bus_error, ser_rx, ser_tx;
	soc_pkg::addr_t addr;
	soc_pkg::word_t wdata, rdata;
	soc_pkg::strb_t wstrb;
	soc_pkg::led_t  leds;

	step_t steps[$];
	soc_pkg::word_t ram_model [`SOC_RAM_WORDS];
	soc_pkg::byte_t rx_model[$];
	soc_pkg::led_t  led_model = '0;
	int errors = 0;
	int checks = 0;
	bit table_ready = 1'b0;

	soc_pkg::word_t bus_rd; // Results of the last access
	int bus_lat;
	time ack_time, tx_fall;
	soc_pkg::byte_t tx_byte;

	tb_clock clock_i (.clk(clk), .resetn(resetn));

	soc_top dut_i (
		.clk       (clk),
		.resetn    (resetn),
		.req       (req),
		.addr      (addr),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.ack       (ack),
		.rdata     (rdata),
		.bus_error (bus_error),
		.leds      (leds),
		.ser_rx    (ser_rx),
		.ser_tx    (ser_tx)
	);

	bind bus_decoder soc_assert assert_i (
		.clk       (clk),
		.resetn    (resetn),
		.req       (req),
		.ack       (ack),
		.bus_error (bus_error)
	);

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic compare(input string what, input soc_pkg::word_t got,
			input soc_pkg::word_t want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// Master side of the four-phase handshake
	task automatic bus_access(input soc_pkg::addr_t a, input soc_pkg::word_t d,
			input soc_pkg::strb_t s);
		int n;
		addr = a;
		wdata = d;
		wstrb = s;
		req = 1'b1;
		bus_lat = 0;
		do begin
			next_cycle();
			bus_lat++;
		end while (!ack && bus_lat < ACK_LIMIT);
		checks++;
		assert (ack) else begin
			errors++;
			$display("No ack within %0d cycles for address %h", ACK_LIMIT, a);
		end
		bus_rd = rdata;
		ack_time = $time;
		req = 1'b0;
		wstrb = '0;
		n = 0;
		while (ack && n < 4) begin
			next_cycle();
			n++;
		end
		checks++;
		assert (!ack) else begin
			errors++;
			$display("ack stayed high after req was dropped for address %h", a);
		end
	endtask

	task automatic drive_serial(input soc_pkg::byte_t b);
		ser_rx = 1'b0;
		#(BIT_NS);
		for (int i = 0; i < 8; i++) begin
			ser_rx = b[i];
			#(BIT_NS);
		end
		ser_rx = 1'b1; // Stop bit
		#(BIT_NS);
	endtask

	task automatic watch_serial();
		@(negedge ser_tx);
		tx_fall = $time;
		#(BIT_NS / 2);
		compare("start bit", soc_pkg::word_t'(ser_tx), 32'h0);
		for (int i = 0; i < 8; i++) begin
			#(BIT_NS);
			tx_byte[i] = ser_tx; // LSB first
		end
		#(BIT_NS);
		compare("stop bit", soc_pkg::word_t'(ser_tx), 32'h1);
	endtask

	task automatic run_step(input step_t st);
		case (st.op)
			OP_WRITE, OP_READ: begin
				bus_access(st.addr, st.wdata, st.strb);
				compare("ack latency", soc_pkg::word_t'(bus_lat), ACK_CYCLES);
				if (st.op == OP_READ)
					compare($sformatf("read data at %h", st.addr), bus_rd, st.exp_val);
			end
			OP_SEND: begin
				fork
					watch_serial();
					bus_access(st.addr, st.wdata, st.strb);
				join
				compare("serial byte", soc_pkg::word_t'(tx_byte), st.exp_val);
				checks++;
				assert (ack_time > tx_fall + 9 * BIT_NS) else begin
					errors++;
					$display("[ERROR] %0t ns: serial write acked before the stop bit", $time);
				end
			end
			OP_RECV: drive_serial(st.wdata[7:0]);
			OP_LEDS: compare("leds", soc_pkg::word_t'(leds), st.exp_val);
			default: compare("bus_error", soc_pkg::word_t'(bus_error), st.exp_val);
		endcase
	endtask

	task automatic add_step(input op_e op, input soc_pkg::addr_t a, input soc_pkg::word_t d,
			input soc_pkg::strb_t s, input soc_pkg::word_t e);
		step_t st;
		st.op = op;
		st.addr = a;
		st.wdata = d;
		st.strb = s;
		st.exp_val = e;
		steps.push_back(st);
	endtask

	function automatic soc_pkg::word_t merge_bytes(soc_pkg::word_t old, soc_pkg::word_t d,
			soc_pkg::strb_t s);
		soc_pkg::word_t mask;
		mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
		return (old & ~mask) | (d & mask);
	endfunction

	task automatic led_write(input soc_pkg::word_t d, input soc_pkg::strb_t s);
		add_step(OP_WRITE, `SOC_LED_ADDR, d, s, '0);
		if (s[0])
			led_model = d[4:0];
		add_step(OP_LEDS, '0, '0, '0, soc_pkg::word_t'(led_model));
	endtask

	task automatic serial_write(input soc_pkg::word_t d, input soc_pkg::strb_t s);
		add_step(OP_SEND, `SOC_UART_ADDR, d, s, {24'h0, d[7:0]});
	endtask

	task automatic serial_in(input soc_pkg::byte_t b);
		add_step(OP_RECV, '0, soc_pkg::word_t'(b), '0, '0);
		if (rx_model.size() < 4)
			rx_model.push_back(b); // Lost when the buffer is full
	endtask

	task automatic serial_read();
		soc_pkg::word_t e;
		e = (rx_model.size() > 0) ? soc_pkg::word_t'(rx_model.pop_front()) : 32'hFFFF_FFFF;
		add_step(OP_READ, `SOC_UART_ADDR, '0, '0, e);
	endtask

	task automatic build_table();
		int unsigned idx [RAM_CASES];
		int unsigned k;
		soc_pkg::word_t d;
		soc_pkg::strb_t s;
		for (int i = 0; i < RAM_CASES; i++) begin
			idx[i] = $urandom_range(`SOC_RAM_WORDS - 1);
			d = $urandom;
			ram_model[idx[i]] = d;
			add_step(OP_WRITE, idx[i] * 4, d, 4'hF, '0);
		end
		for (int i = 0; i < RAM_CASES; i++) begin
			k = idx[$urandom_range(RAM_CASES - 1)];
			s = soc_pkg::strb_t'(1 << $urandom_range(3)); // One byte lane
			d = $urandom;
			ram_model[k] = merge_bytes(ram_model[k], d, s);
			add_step(OP_WRITE, k * 4, d, s, '0);
		end
		for (int i = 0; i < RAM_CASES; i++)
			add_step(OP_READ, idx[i] * 4, '0, '0, ram_model[idx[i]]);
		led_write(32'h0000_0015, 4'h1);
		led_write(32'h0000_000A, 4'h2);
		add_step(OP_READ, `SOC_LED_ADDR, '0, '0, soc_pkg::word_t'(led_model));
		led_write(32'hFFFF_FFEA, 4'hF);
		add_step(OP_READ, `SOC_LED_ADDR, '0, '0, soc_pkg::word_t'(led_model));
		serial_write(32'h0000_00A5, 4'hF);
		serial_write(32'h1234_563C, 4'h1);
		serial_in(8'h5A);
		serial_in(8'hC3);
		serial_in(8'h0F);
		repeat (4) serial_read();
		for (int i = 1; i <= 6; i++)
			serial_in(soc_pkg::byte_t'(i * 17));
		repeat (5) serial_read();
		add_step(OP_BERR, '0, '0, '0, 32'h0);
		add_step(OP_READ, 32'h1000_0000, '0, '0, 32'h0); // Unmapped
		add_step(OP_BERR, '0, '0, '0, 32'h1);
		add_step(OP_READ, idx[0] * 4, '0, '0, ram_model[idx[0]]);
		led_write(32'h0000_0003, 4'h1);
		add_step(OP_BERR, '0, '0, '0, 32'h1);
	endtask

	initial begin
		time limit;
		wait (table_ready);
		limit = steps.size() * 15 * BIT_NS + 20_000; // 15 bit times per step
		#(limit);
		$display("Timeout: the tests did not finish within %0t ns", limit);
		$display("Errors: %0d of %0d checks", errors, checks);
		$display("Something failed");
		$finish;
	end

	initial begin
		req = 1'b0;
		addr = '0;
		wdata = '0;
		wstrb = '0;
		ser_rx = 1'b1;
		void'($urandom(SEED));
		build_table();
		table_ready = 1'b1;
		wait (resetn === 1'b1);
		next_cycle();
		foreach (steps[i]) begin
			run_step(steps[i]);
			next_cycle();
		end
		errors += dut_i.u_decoder.assert_i.fail_count; // Handshake assertion failures
		$display("Errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+source
source/soc_pkg.sv
source/mem_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_port.sv
source/bus_decoder.sv
source/soc_top.sv
tb/tb_clock.sv
tb/soc_assert.sv
tb/soc_tb.sv

// ==== Makefile ====
# Verilator simulation of the peripheral subsystem

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: run clean

run: obj_dir/Vsoc_tb
	obj_dir/Vsoc_tb | tee sim.log
	grep -qx "Everything OK" sim.log

# Rebuilt only when a source or the file list changes
obj_dir/Vsoc_tb: project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module soc_tb

clean:
	rm -rf obj_dir sim.log
